// File: verilog/tex_pkg.sv
package tex_pkg;

    localparam int TEX_NUM_STAGES  = 4;
    localparam int TEX_STAGE_BITS  = 2;
    localparam int TEX_ADDR_BITS   = 32;
    localparam int TEX_COORD_BITS  = 16;
    localparam int TEX_LOG_BITS    = 4;
    localparam int TEX_LOD_BITS    = 3;
    localparam int TEX_LOD_MAX     = 7;
    localparam int TEX_WB_ADR_BITS = 5;

    // Word addresses on the Wishbone port.
    typedef enum logic [TEX_WB_ADR_BITS-1:0] {
        TEX_REG_STAGE   = 5'd0,
        TEX_REG_BASE    = 5'd1,
        TEX_REG_FORMAT  = 5'd2,
        TEX_REG_WRAP    = 5'd3,
        TEX_REG_LOGDIM  = 5'd4,
        TEX_REG_MIPOFF0 = 5'd8
    } tex_reg_e;

    // Encoding equals the byte shift of one texel.
    typedef enum logic [1:0] {
        TEX_FMT_R8     = 2'd0,
        TEX_FMT_RGB565 = 2'd1,
        TEX_FMT_RGBA8  = 2'd2
    } tex_format_e;

    typedef enum logic [1:0] {
        TEX_WRAP_CLAMP  = 2'd0,
        TEX_WRAP_REPEAT = 2'd1,
        TEX_WRAP_MIRROR = 2'd2
    } tex_wrap_e;

    typedef struct packed {
        logic [TEX_ADDR_BITS-1:0]                  base;
        tex_format_e                               format;
        tex_wrap_e                                 wrap_u;
        tex_wrap_e                                 wrap_v;
        logic [TEX_LOG_BITS-1:0]                   logdim_u;
        logic [TEX_LOG_BITS-1:0]                   logdim_v;
        logic [TEX_LOD_MAX:0][TEX_ADDR_BITS-1:0]   mipoff;
    } tex_state_t;

    // Unknown encodings fall back to single bytes.
    function automatic logic [1:0] tex_fmt_shift(tex_format_e fmt);
        case (fmt)
            TEX_FMT_RGB565: return 2'd1;
            TEX_FMT_RGBA8:  return 2'd2;
            default:        return 2'd0;
        endcase
    endfunction

endpackage

// File: verilog/tex_axis_if.sv
interface tex_axis_if;
    import tex_pkg::*;

    logic                             advance;
    logic signed [TEX_COORD_BITS-1:0] coord;
    tex_wrap_e                        mode;
    logic [TEX_LOG_BITS-1:0]          logdim;
    logic [TEX_LOD_BITS-1:0]          lod;

    // Wrapped coordinate and the log dimension of its mip level.
    logic [TEX_COORD_BITS-1:0]        texel;
    logic [TEX_LOG_BITS-1:0]          texel_log;

    modport wrap (
        input  advance, coord, mode, logdim, lod,
        output texel, texel_log
    );

    modport combine (
        output advance,
        input  texel, texel_log
    );

endinterface

// File: verilog/tex_dcr.sv
module tex_dcr (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [tex_pkg::TEX_WB_ADR_BITS-1:0] wb_adr,
    input  logic [tex_pkg::TEX_ADDR_BITS-1:0]   wb_dat_w,
    output logic [tex_pkg::TEX_ADDR_BITS-1:0]   wb_dat_r,
    output logic                                wb_ack,
    input  logic [tex_pkg::TEX_STAGE_BITS-1:0]  stage,
    output tex_pkg::tex_state_t                 tex_state
);
    import tex_pkg::*;

    tex_state_t                states [TEX_NUM_STAGES];
    tex_state_t                cur;
    logic [TEX_STAGE_BITS-1:0] sel;
    logic                      armed;
    logic                      strobe;
    logic                      take;
    logic                      is_mip;
    logic [TEX_ADDR_BITS-1:0]  rd_data;

    assign strobe = wb_cyc && wb_stb;
    // One ack per strobe; re-arm only once the strobe has dropped.
    assign take   = strobe && armed;
    assign is_mip = (wb_adr[4:3] == 2'b01);
    assign cur    = states[sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            armed  <= 1'b1;
        end else begin
            wb_ack <= take;
            if (take) begin
                armed <= 1'b0;
            end else if (!strobe) begin
                armed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= '0;
            for (int i = 0; i < TEX_NUM_STAGES; i++) begin
                states[i] <= '0;
            end
        end else if (take && wb_we) begin
            case (wb_adr)
                TEX_REG_STAGE:  sel <= wb_dat_w[TEX_STAGE_BITS-1:0];
                TEX_REG_BASE:   states[sel].base <= wb_dat_w;
                TEX_REG_FORMAT: states[sel].format <= tex_format_e'(wb_dat_w[1:0]);
                TEX_REG_WRAP: begin
                    states[sel].wrap_u <= tex_wrap_e'(wb_dat_w[1:0]);
                    states[sel].wrap_v <= tex_wrap_e'(wb_dat_w[17:16]);
                end
                TEX_REG_LOGDIM: begin
                    states[sel].logdim_u <= wb_dat_w[3:0];
                    states[sel].logdim_v <= wb_dat_w[19:16];
                end
                default: begin
                    if (is_mip) begin
                        states[sel].mipoff[wb_adr[2:0]] <= wb_dat_w;
                    end
                end
            endcase
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            TEX_REG_STAGE:  rd_data[TEX_STAGE_BITS-1:0] = sel;
            TEX_REG_BASE:   rd_data = cur.base;
            TEX_REG_FORMAT: rd_data[1:0] = cur.format;
            TEX_REG_WRAP: begin
                rd_data[1:0]   = cur.wrap_u;
                rd_data[17:16] = cur.wrap_v;
            end
            TEX_REG_LOGDIM: begin
                rd_data[3:0]   = cur.logdim_u;
                rd_data[19:16] = cur.logdim_v;
            end
            default: begin
                if (is_mip) begin
                    rd_data = cur.mipoff[wb_adr[2:0]];
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wb_dat_r <= rd_data;
        end
    end

    // Request side lookup.
    assign tex_state = states[stage];

endmodule

// File: verilog/tex_wrap.sv
module tex_wrap (
    input logic      clk,
    input logic      rst,
    tex_axis_if.wrap axis
);
    import tex_pkg::*;

    logic [TEX_LOG_BITS-1:0]   lod_ext;
    logic [TEX_LOG_BITS-1:0]   lvl_log;
    logic [TEX_COORD_BITS-1:0] ucoord;
    logic [TEX_COORD_BITS-1:0] mask;
    logic [TEX_COORD_BITS-1:0] low;
    logic                      flip;
    logic [TEX_COORD_BITS-1:0] wrapped;

    assign lod_ext = TEX_LOG_BITS'(axis.lod);
    // Mip level dimension, floored at one texel.
    assign lvl_log = (axis.logdim > lod_ext) ? axis.logdim - lod_ext : '0;
    assign ucoord  = axis.coord;
    assign mask    = ~({TEX_COORD_BITS{1'b1}} << lvl_log);
    assign low     = ucoord & mask;
    assign flip    = ucoord[lvl_log];

    always_comb begin
        case (axis.mode)
            TEX_WRAP_REPEAT: wrapped = low;
            TEX_WRAP_MIRROR: wrapped = flip ? (~ucoord & mask) : low;
            default: begin
                if (ucoord[TEX_COORD_BITS-1]) begin
                    wrapped = '0;
                end else if (ucoord > mask) begin
                    wrapped = mask;
                end else begin
                    wrapped = ucoord;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            axis.texel     <= '0;
            axis.texel_log <= '0;
        end else if (axis.advance) begin
            axis.texel     <= wrapped;
            axis.texel_log <= lvl_log;
        end
    end

endmodule

// File: verilog/tex_addr.sv
module tex_addr (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              req_valid,
    input  logic [tex_pkg::TEX_LOD_BITS-1:0]  req_lod,
    output logic                              req_ready,
    input  tex_pkg::tex_state_t               tex_state,
    tex_axis_if.combine                       axis_u,
    tex_axis_if.combine                       axis_v,
    output logic                              out_valid,
    output logic [tex_pkg::TEX_ADDR_BITS-1:0] out_addr,
    input  logic                              out_ready
);
    import tex_pkg::*;

    logic                     advance;
    logic                     valid1;
    logic [TEX_ADDR_BITS-1:0] off1;
    logic [1:0]               shift1;
    logic [TEX_ADDR_BITS-1:0] texel_off;
    logic [TEX_ADDR_BITS-1:0] next_addr;

    // Whole pipeline stalls while the output is held.
    assign advance        = !(out_valid && !out_ready);
    assign req_ready      = advance;
    assign axis_u.advance = advance;
    assign axis_v.advance = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid1    <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            valid1    <= req_valid;
            out_valid <= valid1;
        end
    end

    // Stage state sampled together with the wrap stage.
    always_ff @(posedge clk) begin
        if (advance) begin
            off1   <= tex_state.base + tex_state.mipoff[req_lod];
            shift1 <= tex_fmt_shift(tex_state.format);
        end
    end

    assign texel_off = (TEX_ADDR_BITS'(axis_v.texel) << axis_u.texel_log)
                     + TEX_ADDR_BITS'(axis_u.texel);
    assign next_addr = off1 + (texel_off << shift1);

    always_ff @(posedge clk) begin
        if (advance) begin
            out_addr <= next_addr;
        end
    end

endmodule

// File: verilog/tex_unit.sv
module tex_unit (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       wb_cyc,
    input  logic                                       wb_stb,
    input  logic                                       wb_we,
    input  logic [tex_pkg::TEX_WB_ADR_BITS-1:0]        wb_adr,
    input  logic [tex_pkg::TEX_ADDR_BITS-1:0]          wb_dat_w,
    output logic [tex_pkg::TEX_ADDR_BITS-1:0]          wb_dat_r,
    output logic                                       wb_ack,
    input  logic                                       req_valid,
    input  logic [tex_pkg::TEX_STAGE_BITS-1:0]         req_stage,
    input  logic [tex_pkg::TEX_LOD_BITS-1:0]           req_lod,
    input  logic signed [tex_pkg::TEX_COORD_BITS-1:0]  req_u,
    input  logic signed [tex_pkg::TEX_COORD_BITS-1:0]  req_v,
    output logic                                       req_ready,
    output logic                                       out_valid,
    output logic [tex_pkg::TEX_ADDR_BITS-1:0]          out_addr,
    input  logic                                       out_ready
);
    import tex_pkg::*;

    tex_state_t tex_state;

    tex_axis_if axis_u ();
    tex_axis_if axis_v ();

    tex_dcr dcr0 (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .stage     (req_stage),
        .tex_state (tex_state)
    );

    // Per-axis request fields.
    assign axis_u.coord  = req_u;
    assign axis_u.mode   = tex_state.wrap_u;
    assign axis_u.logdim = tex_state.logdim_u;
    assign axis_u.lod    = req_lod;

    assign axis_v.coord  = req_v;
    assign axis_v.mode   = tex_state.wrap_v;
    assign axis_v.logdim = tex_state.logdim_v;
    assign axis_v.lod    = req_lod;

    tex_wrap wrap_u (
        .clk  (clk),
        .rst  (rst),
        .axis (axis_u)
    );

    tex_wrap wrap_v (
        .clk  (clk),
        .rst  (rst),
        .axis (axis_v)
    );

    tex_addr addr0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_lod   (req_lod),
        .req_ready (req_ready),
        .tex_state (tex_state),
        .axis_u    (axis_u),
        .axis_v    (axis_v),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_ready (out_ready)
    );

endmodule

// File: testbench/tb_clock.sv
module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

// File: testbench/tex_unit_props.sv
module tex_unit_props (
    input logic                                      clk,
    input logic                                      rst,
    input logic                                      wb_cyc,
    input logic                                      wb_stb,
    input logic                                      wb_we,
    input logic [tex_pkg::TEX_WB_ADR_BITS-1:0]       wb_adr,
    input logic [tex_pkg::TEX_ADDR_BITS-1:0]         wb_dat_w,
    input logic [tex_pkg::TEX_ADDR_BITS-1:0]         wb_dat_r,
    input logic                                      wb_ack,
    input logic                                      req_valid,
    input logic [tex_pkg::TEX_STAGE_BITS-1:0]        req_stage,
    input logic [tex_pkg::TEX_LOD_BITS-1:0]          req_lod,
    input logic signed [tex_pkg::TEX_COORD_BITS-1:0] req_u,
    input logic signed [tex_pkg::TEX_COORD_BITS-1:0] req_v,
    input logic                                      req_ready,
    input logic                                      out_valid,
    input logic [tex_pkg::TEX_ADDR_BITS-1:0]         out_addr,
    input logic                                      out_ready
);
    import tex_pkg::*;

    // Shadow register words per stage, indexed by word address 0 to 15.
    logic [31:0] regs_m [TEX_NUM_STAGES][16];
    logic [1:0]  sel_m;
    logic        armed_m;
    logic        ack_m;
    logic        rd_chk;
    logic [31:0] rd_exp;
    logic        strobe_m;
    logic        take_m;
    logic [31:0] exp_q [4];
    logic [1:0]  wr_ptr;
    logic [1:0]  rd_ptr;
    logic [2:0]  exp_cnt;
    logic        push;
    logic        pop;
    int          fail_count = 0;

    function automatic logic [31:0] reg_mask(logic [4:0] adr);
        case (adr)
            5'd1:    return 32'hffff_ffff;
            5'd2:    return 32'h0000_0003;
            5'd3:    return 32'h0003_0003;
            5'd4:    return 32'h000f_000f;
            default: return (adr >= 5'd8 && adr <= 5'd15) ? 32'hffff_ffff : 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] read_value(logic [4:0] adr);
        if (adr == 5'd0) begin
            return {30'd0, sel_m};
        end
        if (adr[4]) begin
            return 32'h0;
        end
        return regs_m[sel_m][adr[3:0]];
    endfunction

    function automatic int level_log(logic [3:0] lgd, logic [2:0] lod);
        return (lgd > {1'b0, lod}) ? int'(lgd - {1'b0, lod}) : 0;
    endfunction

    function automatic logic [31:0] wrap_coord(logic [15:0] c, logic [1:0] mode, int lg);
        logic [15:0] dim_m1;
        dim_m1 = 16'((32'd1 << lg) - 32'd1);
        if (mode == TEX_WRAP_REPEAT) begin
            return 32'(c & dim_m1);
        end
        if (mode == TEX_WRAP_MIRROR) begin
            return c[lg] ? 32'(~c & dim_m1) : 32'(c & dim_m1);
        end
        if (c[15]) begin
            return 32'h0;
        end
        return (c > dim_m1) ? 32'(dim_m1) : 32'(c);
    endfunction

    // Word 2 is the format, 3 the wrap modes, 4 the log dimensions.
    function automatic logic [31:0] expect_addr(logic [1:0] st, logic [2:0] lod,
                                                logic [15:0] u, logic [15:0] v);
        int          lu;
        int          lv;
        int          sh;
        logic [31:0] tu;
        logic [31:0] tv;
        lu = level_log(regs_m[st][4'd4][3:0], lod);
        lv = level_log(regs_m[st][4'd4][19:16], lod);
        case (regs_m[st][4'd2][1:0])
            2'd1:    sh = 1;
            2'd2:    sh = 2;
            default: sh = 0;
        endcase
        tu = wrap_coord(u, regs_m[st][4'd3][1:0], lu);
        tv = wrap_coord(v, regs_m[st][4'd3][17:16], lv);
        return regs_m[st][4'd1] + regs_m[st][{1'b1, lod}] + (((tv << lu) + tu) << sh);
    endfunction

    assign strobe_m = wb_cyc && wb_stb;
    assign take_m   = strobe_m && armed_m;
    assign push     = req_valid && req_ready;
    assign pop      = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            armed_m <= 1'b1;
            ack_m   <= 1'b0;
            rd_chk  <= 1'b0;
            sel_m   <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            exp_cnt <= '0;
            for (int s = 0; s < TEX_NUM_STAGES; s++) begin
                for (int a = 0; a < 16; a++) begin
                    regs_m[s][a] <= '0;
                end
            end
        end else begin
            ack_m  <= take_m;
            rd_chk <= take_m && !wb_we;
            if (take_m) begin
                armed_m <= 1'b0;
                rd_exp  <= read_value(wb_adr);
            end else if (!strobe_m) begin
                armed_m <= 1'b1;
            end
            if (take_m && wb_we) begin
                if (wb_adr == 5'd0) begin
                    sel_m <= wb_dat_w[1:0];
                end else if (!wb_adr[4]) begin
                    regs_m[sel_m][wb_adr[3:0]] <= wb_dat_w & reg_mask(wb_adr);
                end
            end
            if (push) begin
                exp_q[wr_ptr] <= expect_addr(req_stage, req_lod, req_u, req_v);
                wr_ptr        <= wr_ptr + 2'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            exp_cnt <= exp_cnt + 3'(push) - 3'(pop);
        end
    end

    a_reset: assert property (@(posedge clk) rst |=> !wb_ack && !out_valid)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch at %0t: ack or out_valid high after reset", $time);
        end

    a_ack: assert property (@(posedge clk) disable iff (rst) wb_ack == ack_m)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch at %0t: wb_ack is %b, expected %b", $time, wb_ack, ack_m);
        end

    a_read: assert property (@(posedge clk) disable iff (rst) rd_chk |-> wb_dat_r == rd_exp)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch at %0t: read %h, expected %h", $time, wb_dat_r, rd_exp);
        end

    a_out: assert property (@(posedge clk) disable iff (rst)
        pop |-> exp_cnt != 0 && out_addr == exp_q[rd_ptr])
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch at %0t: out_addr %h, expected %h", $time, out_addr, exp_q[rd_ptr]);
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_addr))
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch at %0t: result changed under back-pressure", $time);
        end

    a_stall: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |-> !req_ready)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch at %0t: req_ready high while stalled", $time);
        end

    // Two unstalled edges carry a request to the output.
    a_latency: assert property (@(posedge clk) disable iff (rst)
        req_ready && $past(req_ready) |=> out_valid == $past(req_valid, 2))
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch at %0t: out_valid latency is not two cycles", $time);
        end

endmodule

bind tex_unit tex_unit_props props0 (.*);

// File: testbench/tex_unit_tb.sv
module tex_unit_tb;
    import tex_pkg::*;

    localparam int WB_TIMEOUT    = 20;
    localparam int REQ_TIMEOUT   = 50;
    localparam int DRAIN_TIMEOUT = 100;
    localparam int NUM_REQS      = 400;

    logic                      clk;
    logic                      rst;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [TEX_WB_ADR_BITS-1:0] wb_adr;
    logic [TEX_ADDR_BITS-1:0]  wb_dat_w;
    logic [TEX_ADDR_BITS-1:0]  wb_dat_r;
    logic                      wb_ack;
    logic                      req_valid;
    logic [TEX_STAGE_BITS-1:0] req_stage;
    logic [TEX_LOD_BITS-1:0]   req_lod;
    logic signed [TEX_COORD_BITS-1:0] req_u;
    logic signed [TEX_COORD_BITS-1:0] req_v;
    logic                      req_ready;
    logic                      out_valid;
    logic [TEX_ADDR_BITS-1:0]  out_addr;
    logic                      out_ready;
    logic                      hold_ready;
    logic [1:0]                st;
    int                        drain_wait;

    tb_clock clk_gen (.clk(clk));

    tex_unit dut0 (.*);

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic wb_cycle(input logic we, input logic [TEX_WB_ADR_BITS-1:0] adr,
                            input logic [TEX_ADDR_BITS-1:0] dat);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(posedge clk);
        #1;
        while (!wb_ack) begin
            if (waited == WB_TIMEOUT) abort_run("Wishbone ack did not arrive in time");
            waited++;
            @(posedge clk);
            #1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        // Strobe low for one edge.
        @(posedge clk);
        #1;
    endtask

    task automatic send_request(input logic [1:0] stage, input logic [2:0] lod,
                                input logic [15:0] u, input logic [15:0] v);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req_stage = stage;
        req_lod   = lod;
        req_u     = u;
        req_v     = v;
        #1;
        while (!req_ready) begin
            if (waited == REQ_TIMEOUT) abort_run("request was not accepted in time");
            waited++;
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // Spans negative values and values beyond most dimensions.
    function automatic logic [15:0] rand_coord();
        return 16'($urandom_range(0, 8191)) - 16'd4096;
    endfunction

    task automatic program_stage(input logic [1:0] stage);
        wb_cycle(1'b1, TEX_REG_STAGE, 32'(stage));
        wb_cycle(1'b1, TEX_REG_BASE, $urandom);
        wb_cycle(1'b1, TEX_REG_FORMAT, $urandom_range(0, 3));
        wb_cycle(1'b1, TEX_REG_WRAP, ($urandom & 32'hfffc_fffc)
                 | ($urandom_range(0, 2) << 16) | $urandom_range(0, 2));
        wb_cycle(1'b1, TEX_REG_LOGDIM, ($urandom & 32'hfff0_fff0)
                 | ($urandom_range(0, 12) << 16) | $urandom_range(0, 12));
        for (int m = 0; m <= TEX_LOD_MAX; m++) begin
            wb_cycle(1'b1, 5'(int'(TEX_REG_MIPOFF0) + m), $urandom);
        end
    endtask

    // Ready is random unless held, sampled at the edge.
    always @(posedge clk) begin
        automatic logic hold_now = hold_ready;
        #1;
        out_ready = hold_now ? 1'b1 : ($urandom_range(0, 3) != 0);
    end

    always @(negedge clk) begin
        if (dut0.props0.fail_count != 0) abort_run("a DUT check failed");
    end

    initial begin
        void'($urandom(32'h235bacad));
        rst        = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        req_valid  = 1'b0;
        req_stage  = '0;
        req_lod    = '0;
        req_u      = '0;
        req_v      = '0;
        out_ready  = 1'b1;
        hold_ready = 1'b1;
        drain_wait = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int s = 0; s < TEX_NUM_STAGES; s++) begin
            program_stage(2'(s));
        end
        wb_cycle(1'b1, 5'd6, $urandom);
        wb_cycle(1'b1, 5'd20, $urandom);
        for (int i = 0; i < 64; i++) begin
            if (i % 8 == 0) wb_cycle(1'b1, TEX_REG_STAGE, $urandom_range(0, 3));
            wb_cycle(1'b0, 5'($urandom_range(0, 31)), 32'h0);
        end

        for (int i = 0; i < NUM_REQS; i++) begin
            hold_ready = (i < NUM_REQS / 4);
            st = 2'($urandom_range(0, 3));
            if (hold_ready && i % 4 == 0) begin
                wb_cycle(1'b1, TEX_REG_STAGE, 32'(st));
                // The base write lands on the edge that accepts the request.
                fork
                    send_request(st, 3'($urandom_range(0, 7)), rand_coord(), rand_coord());
                    wb_cycle(1'b1, TEX_REG_BASE, $urandom);
                join
            end else begin
                send_request(st, 3'($urandom_range(0, 7)), rand_coord(), rand_coord());
                repeat ($urandom_range(0, 2)) begin
                    @(posedge clk);
                    #1;
                end
            end
            if (i % 100 == 99) program_stage(2'($urandom_range(0, 3)));
        end

        hold_ready = 1'b1;
        while (dut0.props0.exp_cnt != 0) begin
            if (drain_wait == DRAIN_TIMEOUT) abort_run("results did not drain in time");
            drain_wait++;
            @(posedge clk);
            #1;
        end

        if (dut0.props0.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("DUT checks reported failures");
        end
    end

endmodule

// File: src.f
verilog/tex_pkg.sv
verilog/tex_axis_if.sv
verilog/tex_dcr.sv
verilog/tex_wrap.sv
verilog/tex_addr.sv
verilog/tex_unit.sv
testbench/tb_clock.sv
testbench/tex_unit_props.sv
testbench/tex_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tex_unit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
